// ==== hw/exe_pkg.sv ====
// widths, operation codes and bundle types shared by the blocks of the execute stage
// modules pull these in with a wildcard import in their header
package exe_pkg;

  localparam int XLEN      = 64;
  localparam int RIDX_W    = 5;
  localparam int SHAMT_W   = $clog2(XLEN); // shift amount comes from the low bits of op2
  localparam int MUL_STEPS = 64;           // one multiplier bit retired per cycle
  localparam int MUL_CNT_W = $clog2(MUL_STEPS);

  // operation kind as handed over by decode
  typedef enum logic [4:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU,
    OP_BRANCH, // condition picked by funct3
    OP_JAL,
    OP_JALR,
    OP_LOAD,
    OP_STORE,
    OP_MUL
  } exe_op_e;

  typedef struct packed {
    exe_op_e           op;
    logic [2:0]        funct3;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op2;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   pc_pred; // next pc that fetch went on with
    logic [RIDX_W-1:0] rd;
    logic              rd_wen;
  } decoded_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   rd_wdata;
    logic [XLEN-1:0]   memaddr;
    logic [XLEN-1:0]   pc_jmpaddr;
    logic [2:0]        funct3;
    logic [RIDX_W-1:0] rd;
    logic              rd_wen;
    logic              memren;
    logic              memwen;
    logic              pc_jmp; // fetch has to be redirected to pc_jmpaddr
  } executed_t;

  // single-cycle part of the result
  typedef struct packed {
    logic [XLEN-1:0] rd_wdata;
    logic [XLEN-1:0] memaddr;
    logic [XLEN-1:0] next_pc;
    logic            memren;
    logic            memwen;
  } alu_res_t;

endpackage

// ==== hw/exe_ctrl.sv ====
// sequencing of the execute stage, owns the decoded and executed handshakes
// a single instruction is held from its decoded transfer until its executed transfer
module exe_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic i_decoded_req,
  input  logic i_is_mul,       // op of the instruction being offered
  input  logic i_iter_done,
  input  logic i_executed_ack,
  output logic o_decoded_ack,
  output logic o_load,
  output logic o_start,
  output logic o_executed_req
);

  typedef enum logic [1:0] {
    IDLE,
    MUL_RUN,
    DONE
  } state_e;

  state_e state;
  state_e state_nxt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (o_load) begin
          state_nxt = i_is_mul ? MUL_RUN : DONE;
        end
      end
      MUL_RUN: begin
        if (i_iter_done) begin
          state_nxt = DONE;
        end
      end
      DONE: begin
        if (i_executed_ack) begin
          state_nxt = IDLE; // ack is high again on the next cycle
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  // only accept while nothing is in flight so a running multiply is never overwritten
  assign o_decoded_ack  = (state == IDLE);
  assign o_load         = i_decoded_req & o_decoded_ack;
  assign o_start        = o_load & i_is_mul;
  assign o_executed_req = (state == DONE);

endmodule

// ==== hw/iter_timer.sv ====
// iteration counter for the multiplier, started together with it
// o_done stays high while idle so the controller can leave MUL_RUN on it
module iter_timer
  import exe_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic i_start,
  output logic o_done
);

  logic [MUL_CNT_W-1:0] cnt;

  // loaded one short so that done is seen on the edge that retires the last bit
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (i_start) begin
      cnt <= MUL_CNT_W'(MUL_STEPS - 1);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign o_done = (cnt == '0) & ~i_start;

endmodule

// ==== hw/alu_unit.sv ====
// single-cycle datapath of the execute stage
// arithmetic, compares, branch resolution, next pc and load/store address
module alu_unit
  import exe_pkg::*;
(
  input  decoded_t i_dec,
  output alu_res_t o_res
);

  logic [XLEN-1:0]    pc_plus4;
  logic [XLEN-1:0]    pc_target;
  logic [XLEN-1:0]    reg_target;
  logic [XLEN-1:0]    alu_out;
  logic [SHAMT_W-1:0] shamt;
  logic               eq;
  logic               lt;
  logic               ltu;
  logic               taken;

  assign pc_plus4   = i_dec.pc + XLEN'(4);
  assign pc_target  = i_dec.pc + i_dec.imm;
  assign reg_target = i_dec.op1 + i_dec.imm; // jalr target and load/store address
  assign shamt      = i_dec.op2[SHAMT_W-1:0];

  assign eq  = (i_dec.op1 == i_dec.op2);
  assign lt  = ($signed(i_dec.op1) < $signed(i_dec.op2));
  assign ltu = (i_dec.op1 < i_dec.op2);

  always_comb begin
    case (i_dec.funct3)
      3'b000:  taken = eq;   // beq
      3'b001:  taken = ~eq;  // bne
      3'b100:  taken = lt;   // blt
      3'b101:  taken = ~lt;  // bge
      3'b110:  taken = ltu;  // bltu
      3'b111:  taken = ~ltu; // bgeu
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (i_dec.op)
      OP_ADD:  alu_out = i_dec.op1 + i_dec.op2;
      OP_SUB:  alu_out = i_dec.op1 - i_dec.op2;
      OP_AND:  alu_out = i_dec.op1 & i_dec.op2;
      OP_OR:   alu_out = i_dec.op1 | i_dec.op2;
      OP_XOR:  alu_out = i_dec.op1 ^ i_dec.op2;
      OP_SLL:  alu_out = i_dec.op1 << shamt;
      OP_SRL:  alu_out = i_dec.op1 >> shamt;
      OP_SRA:  alu_out = $unsigned($signed(i_dec.op1) >>> shamt);
      OP_SLT:  alu_out = XLEN'(lt);
      OP_SLTU: alu_out = XLEN'(ltu);
      default: alu_out = '0;
    endcase
  end

  always_comb begin
    o_res          = '0;
    o_res.next_pc  = pc_plus4;

    case (i_dec.op)
      OP_BRANCH: begin
        if (taken) begin
          o_res.next_pc = pc_target;
        end
      end
      OP_JAL: begin
        o_res.rd_wdata = pc_plus4;
        o_res.next_pc  = pc_target;
      end
      OP_JALR: begin
        o_res.rd_wdata = pc_plus4;
        o_res.next_pc  = {reg_target[XLEN-1:1], 1'b0};
      end
      OP_LOAD: begin
        o_res.memaddr = reg_target; // data comes back in the memory stage
        o_res.memren  = 1'b1;
      end
      OP_STORE: begin
        o_res.rd_wdata = i_dec.op2; // store data travels in rd_wdata
        o_res.memaddr  = reg_target;
        o_res.memwen   = 1'b1;
      end
      OP_MUL: begin
        o_res.rd_wdata = '0;
      end
      default: begin
        o_res.rd_wdata = alu_out;
      end
    endcase
  end

endmodule

// ==== hw/mul_unit.sv ====
// shift-add multiplier, one bit of the multiplier per cycle
// gives the low XLEN bits of the product, which is the same for signed and unsigned
module mul_unit
  import exe_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            i_start,
  input  logic [XLEN-1:0] i_op1,
  input  logic [XLEN-1:0] i_op2,
  output logic [XLEN-1:0] o_product
);

  logic [XLEN-1:0] mcand;  // shifted left each step, bits past XLEN drop off
  logic [XLEN-1:0] mplier; // shifted right each step
  logic [XLEN-1:0] acc;
  logic [XLEN-1:0] acc_add;

  // partial product for the current multiplier bit
  assign acc_add = mplier[0] ? mcand : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      mcand  <= '0;
      mplier <= '0;
      acc    <= '0;
    end else if (i_start) begin
      mcand  <= i_op1;
      mplier <= i_op2;
      acc    <= '0;
    end else begin
      // once the multiplier is empty nothing more is added and acc holds
      acc    <= acc + acc_add;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign o_product = acc;

endmodule

// ==== hw/exe_stage.sv ====
// execute stage top, takes one decoded instruction and offers its executed bundle
// result fields read zero whenever no result is being offered
module exe_stage
  import exe_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      i_decoded_req,
  output logic      o_decoded_ack,
  input  decoded_t  i_decoded,
  output logic      o_executed_req,
  input  logic      i_executed_ack,
  output executed_t o_executed
);

  decoded_t        dec_q;
  alu_res_t        alu_res;
  executed_t       exe_d;
  logic            load;
  logic            start;
  logic            iter_done;
  logic [XLEN-1:0] product;

  exe_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .i_decoded_req  (i_decoded_req),
    .i_is_mul       (i_decoded.op == OP_MUL),
    .i_iter_done    (iter_done),
    .i_executed_ack (i_executed_ack),
    .o_decoded_ack  (o_decoded_ack),
    .o_load         (load),
    .o_start        (start),
    .o_executed_req (o_executed_req)
  );

  // held for the whole time the instruction is in flight
  always_ff @(posedge clk) begin
    if (load) begin
      dec_q <= i_decoded;
    end
  end

  iter_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .i_start (start),
    .o_done  (iter_done)
  );

  // operands taken straight from the input, the latch fills on the same edge
  mul_unit u_mul (
    .clk       (clk),
    .rst       (rst),
    .i_start   (start),
    .i_op1     (i_decoded.op1),
    .i_op2     (i_decoded.op2),
    .o_product (product)
  );

  alu_unit u_alu (
    .i_dec (dec_q),
    .o_res (alu_res)
  );

  always_comb begin
    exe_d            = '0;
    exe_d.pc         = dec_q.pc;
    exe_d.rd_wdata   = (dec_q.op == OP_MUL) ? product : alu_res.rd_wdata;
    exe_d.memaddr    = alu_res.memaddr;
    exe_d.pc_jmpaddr = alu_res.next_pc;
    exe_d.funct3     = dec_q.funct3;
    exe_d.rd         = dec_q.rd;
    exe_d.rd_wen     = dec_q.rd_wen;
    exe_d.memren     = alu_res.memren;
    exe_d.memwen     = alu_res.memwen;
    exe_d.pc_jmp     = (alu_res.next_pc != dec_q.pc_pred); // misprediction, redirect fetch
  end

  assign o_executed = o_executed_req ? exe_d : '0;

endmodule

// ==== verif/exe_props.sv ====
// handshake and timing rules of the execute stage as concurrent assertions
// attached to every exe_stage instance by the bind at the bottom
module exe_props
  import exe_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      o_decoded_ack,
  input logic      o_executed_req,
  input logic      i_executed_ack,
  input executed_t o_executed
);

  timeunit 1ns;
  timeprecision 1ps;

  // an offered result waits for its ack without changing
  a_req_held: assert property (@(posedge clk) disable iff (rst)
    o_executed_req && !i_executed_ack |=> o_executed_req && $stable(o_executed))
    else $error("executed request dropped or result changed before the ack");

  a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
    o_executed_req |-> !o_decoded_ack)
    else $error("decoded ack high while a result is offered");

  a_gated: assert property (@(posedge clk) !o_executed_req |-> o_executed == '0)
    else $error("executed bundle not zero while no request is offered");

  a_reset: assert property (@(posedge clk) rst |=> !o_executed_req)
    else $error("executed request high after reset");

endmodule

bind exe_stage exe_props u_props (.*);

// ==== verif/exe_tb.sv ====
// testbench for the execute stage, runs a fixed vector table and then random vectors
// each instruction goes through both handshakes with a random back-pressure hold
module exe_tb
  import exe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RAND  = 40;
  localparam int TIMEOUT = 200; // cycles allowed for any single wait
  localparam logic [XLEN-1:0] ONES = '1;
  localparam logic [XLEN-1:0] TOP  = {1'b1, {(XLEN-1){1'b0}}};

  logic      clk            = 1'b0;
  logic      rst            = 1'b1;
  logic      i_decoded_req  = 1'b0;
  logic      i_executed_ack = 1'b0;
  decoded_t  i_decoded      = '0;
  logic      o_decoded_ack;
  logic      o_executed_req;
  executed_t o_executed;
  decoded_t  tbl_dec[$];
  executed_t tbl_exp[$];
  int        mismatch_cnt   = 0;
  int        proto_cnt      = 0;

  always #20 clk = ~clk;

  exe_stage uut (
    .clk            (clk),
    .rst            (rst),
    .i_decoded_req  (i_decoded_req),
    .o_decoded_ack  (o_decoded_ack),
    .i_decoded      (i_decoded),
    .o_executed_req (o_executed_req),
    .i_executed_ack (i_executed_ack),
    .o_executed     (o_executed)
  );

  // pass-through fields and flags follow from the decoded bundle
  function automatic executed_t expect_from(decoded_t d, logic [XLEN-1:0] wdata,
                                            logic [XLEN-1:0] maddr, logic [XLEN-1:0] npc);
    executed_t e;
    e            = '0;
    e.pc         = d.pc;
    e.rd_wdata   = wdata;
    e.memaddr    = maddr;
    e.pc_jmpaddr = npc;
    e.funct3     = d.funct3;
    e.rd         = d.rd;
    e.rd_wen     = d.rd_wen;
    e.memren     = (d.op == OP_LOAD);
    e.memwen     = (d.op == OP_STORE);
    e.pc_jmp     = (npc != d.pc_pred);
    return e;
  endfunction

  function automatic void add_entry(exe_op_e op, logic [2:0] f3, logic [XLEN-1:0] pc,
      logic [XLEN-1:0] op1, logic [XLEN-1:0] op2, logic [XLEN-1:0] imm,
      logic [XLEN-1:0] pred, logic [XLEN-1:0] wdata, logic [XLEN-1:0] maddr,
      logic [XLEN-1:0] npc);
    decoded_t d;
    d = '{op, f3, pc, op1, op2, imm, pred, RIDX_W'(tbl_dec.size() + 1),
          !(op inside {OP_BRANCH, OP_STORE})};
    tbl_dec.push_back(d);
    tbl_exp.push_back(expect_from(d, wdata, maddr, npc));
  endfunction

  function automatic executed_t model_exec(decoded_t d);
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] maddr;
    logic [XLEN-1:0] npc;
    logic            cond;
    wdata = '0;
    maddr = '0;
    npc   = d.pc + 64'd4;
    case (d.funct3)
      3'd0:    cond = (d.op1 == d.op2);
      3'd1:    cond = (d.op1 != d.op2);
      3'd4:    cond = ($signed(d.op1) < $signed(d.op2));
      3'd5:    cond = ($signed(d.op1) >= $signed(d.op2));
      3'd6:    cond = (d.op1 < d.op2);
      3'd7:    cond = (d.op1 >= d.op2);
      default: cond = 1'b0;
    endcase
    case (d.op)
      OP_ADD:    wdata = d.op1 + d.op2;
      OP_SUB:    wdata = d.op1 - d.op2;
      OP_AND:    wdata = d.op1 & d.op2;
      OP_OR:     wdata = d.op1 | d.op2;
      OP_XOR:    wdata = d.op1 ^ d.op2;
      OP_SLL:    wdata = d.op1 << d.op2[5:0];
      OP_SRL:    wdata = d.op1 >> d.op2[5:0];
      OP_SRA:    wdata = $signed(d.op1) >>> d.op2[5:0];
      OP_SLT:    wdata = ($signed(d.op1) < $signed(d.op2)) ? 64'd1 : 64'd0;
      OP_SLTU:   wdata = (d.op1 < d.op2) ? 64'd1 : 64'd0;
      OP_BRANCH: npc = cond ? d.pc + d.imm : npc;
      OP_MUL:    wdata = d.op1 * d.op2; // only the low word is kept
      default:   wdata = '0;
    endcase
    return expect_from(d, wdata, maddr, npc);
  endfunction

  function automatic decoded_t random_dec();
    decoded_t d;
    int       k;
    k         = $urandom_range(0, 11);
    d         = '0;
    d.op      = (k == 11) ? OP_MUL : exe_op_e'(k);
    d.funct3  = 3'($urandom_range(0, 7));
    d.funct3  = (d.funct3 inside {3'd2, 3'd3}) ? d.funct3 + 3'd2 : d.funct3;
    d.pc      = {$urandom, $urandom} & ~64'h3;
    d.op1     = {$urandom, $urandom};
    d.op2     = ($urandom_range(0, 3) == 0) ? d.op1 : {$urandom, $urandom};
    d.imm     = {$urandom, $urandom} & ~64'h1;
    d.pc_pred = ($urandom_range(0, 1) == 1) ? d.pc + 64'd4 : d.pc + d.imm;
    d.rd      = RIDX_W'($urandom);
    d.rd_wen  = 1'($urandom);
    return d;
  endfunction

  task automatic check_field(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      mismatch_cnt++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_rule(logic ok, string what);
    assert (ok === 1'b1) else begin
      proto_cnt++;
      $display("error at %0t ns: %s", $time, what);
    end
  endtask

  task automatic abort_run(string why);
    $display("timeout at %0t ns: %s", $time, why);
    $display("*** FAILED ***");
    $finish;
  endtask

  // one instruction through both handshakes, outputs are sampled on the falling edge
  task automatic run_vec(decoded_t d, executed_t exp);
    int        waited;
    int        lat;
    executed_t held;
    @(posedge clk);
    i_decoded     <= d;
    i_decoded_req <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!o_decoded_ack) begin
      waited++;
      if (waited > TIMEOUT) abort_run("decoded ack never came");
      @(negedge clk);
    end
    @(posedge clk); // decoded transfer
    i_decoded_req <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (!o_executed_req) begin
      check_rule(o_executed === '0, "executed bundle not zero while no request is offered");
      check_rule(!o_decoded_ack, "decoded ack high while an instruction is in flight");
      if (lat > TIMEOUT) abort_run("executed request never came");
      @(negedge clk);
      lat++;
    end
    check_field("latency", lat, (d.op == OP_MUL) ? MUL_STEPS + 1 : 1);
    check_field("pc", o_executed.pc, exp.pc);
    check_field("rd_wdata", o_executed.rd_wdata, exp.rd_wdata);
    check_field("memaddr", o_executed.memaddr, exp.memaddr);
    check_field("pc_jmpaddr", o_executed.pc_jmpaddr, exp.pc_jmpaddr);
    check_field("funct3", o_executed.funct3, exp.funct3);
    check_field("rd", o_executed.rd, exp.rd);
    check_field("rd_wen", o_executed.rd_wen, exp.rd_wen);
    check_field("memren", o_executed.memren, exp.memren);
    check_field("memwen", o_executed.memwen, exp.memwen);
    check_field("pc_jmp", o_executed.pc_jmp, exp.pc_jmp);
    held = o_executed;
    repeat ($urandom_range(0, 10)) begin
      @(negedge clk);
      check_rule(o_executed_req && o_executed === held, "result not held under back-pressure");
      check_rule(!o_decoded_ack, "decoded ack high while a result is pending");
    end
    @(posedge clk);
    i_executed_ack <= 1'b1;
    @(posedge clk); // executed transfer
    i_executed_ack <= 1'b0;
    @(negedge clk);
    check_rule(!o_executed_req && o_executed === '0, "result still offered after the ack");
    check_rule(o_decoded_ack, "decoded ack not back after the executed transfer");
  endtask

  initial begin
    decoded_t d;
    void'($urandom(32'h6669));
    //        op        f3    pc       op1        op2       imm       pred     wdata    maddr    npc
    add_entry(OP_ADD,  3'd0, 64'h100, 64'd5,    64'd7,    64'd0,    64'h104, 64'd12,  64'd0, 64'h104);
    add_entry(OP_SUB,  3'd0, 64'h100, 64'd3,    64'd5,    64'd0,    64'h104, ~64'd1,  64'd0, 64'h104);
    add_entry(OP_AND,  3'd0, 64'h100, 64'hf0f0, 64'h0ff0, 64'd0,    64'h200, 64'hf0,  64'd0, 64'h104);
    add_entry(OP_OR,   3'd0, 64'h100, 64'hf000, 64'h000f, 64'd0,    64'h104, 64'hf00f, 64'd0, 64'h104);
    add_entry(OP_XOR,  3'd0, 64'h100, 64'hff,   64'h0f,   64'd0,    64'h104, 64'hf0,  64'd0, 64'h104);
    add_entry(OP_SLL,  3'd0, 64'h100, 64'd1,    64'h43,   64'd0,    64'h104, 64'd8,   64'd0, 64'h104);
    add_entry(OP_SRL,  3'd0, 64'h100, TOP, 64'd4, 64'd0, 64'h104, 64'h0800000000000000, 64'd0,
              64'h104);
    add_entry(OP_SRA,  3'd0, 64'h100, TOP, 64'd4, 64'd0, 64'h104, 64'hf800000000000000, 64'd0,
              64'h104);
    add_entry(OP_SLT,  3'd0, 64'h100, ONES,     64'd1,    64'd0,    64'h104, 64'd1,   64'd0, 64'h104);
    add_entry(OP_SLTU, 3'd0, 64'h100, ONES,     64'd1,    64'd0,    64'h104, 64'd0,   64'd0, 64'h104);
    // branches at 0x200 with offset 0x40, some predicted wrong
    add_entry(OP_BRANCH, 3'd0, 64'h200, 64'd9, 64'd9, 64'h40, 64'h240, 64'd0, 64'd0, 64'h240);
    add_entry(OP_BRANCH, 3'd1, 64'h200, 64'd9, 64'd9, 64'h40, 64'h240, 64'd0, 64'd0, 64'h204);
    add_entry(OP_BRANCH, 3'd4, 64'h200, ONES,  64'd1, 64'h40, 64'h204, 64'd0, 64'd0, 64'h240);
    add_entry(OP_BRANCH, 3'd5, 64'h200, ONES,  64'd1, 64'h40, 64'h204, 64'd0, 64'd0, 64'h204);
    add_entry(OP_BRANCH, 3'd6, 64'h200, ONES,  64'd1, 64'h40, 64'h204, 64'd0, 64'd0, 64'h204);
    add_entry(OP_BRANCH, 3'd7, 64'h200, ONES,  64'd1, 64'h40, 64'h240, 64'd0, 64'd0, 64'h240);
    add_entry(OP_JAL,  3'd0, 64'h300, 64'd0, 64'd0, 64'h100, 64'h304, 64'h304, 64'd0, 64'h400);
    add_entry(OP_JALR, 3'd0, 64'h300, 64'h1001, 64'd0, 64'h10, 64'h1010, 64'h304, 64'd0, 64'h1010);
    add_entry(OP_LOAD, 3'd3, 64'h400, 64'h8000, 64'd0, ~64'hf, 64'h404, 64'd0, 64'h7ff0, 64'h404);
    add_entry(OP_STORE, 3'd3, 64'h400, 64'h8000, 64'hdeadbeef, 64'd8, 64'h404, 64'hdeadbeef,
              64'h8008, 64'h404);
    add_entry(OP_MUL,  3'd0, 64'h500, 64'd0,    ONES,     64'd0,    64'h504, 64'd0,   64'd0, 64'h504);
    add_entry(OP_MUL,  3'd0, 64'h500, ONES,     ONES,     64'd0,    64'h504, 64'd1,   64'd0, 64'h504);
    add_entry(OP_MUL,  3'd0, 64'h500, TOP,      64'd3,    64'd0,    64'h504, TOP,     64'd0, 64'h504);
    add_entry(OP_MUL,  3'd0, 64'h500, 64'h1234, 64'h10,   64'd0,    64'h504, 64'h12340, 64'd0, 64'h504);
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_rule(o_decoded_ack && !o_executed_req, "handshake outputs wrong after reset");
    foreach (tbl_dec[i]) run_vec(tbl_dec[i], tbl_exp[i]);
    for (int n = 0; n < N_RAND; n++) begin
      d = random_dec();
      run_vec(d, model_exec(d));
    end
    $display("errors: %0d mismatches, %0d protocol errors", mismatch_cnt, proto_cnt);
    if (mismatch_cnt + proto_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== exe_sub.f ====
hw/exe_pkg.sv
hw/exe_ctrl.sv
hw/iter_timer.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/exe_stage.sv
verif/exe_props.sv
verif/exe_tb.sv
